// ==== flist.f ====
verilog/pcie_phy_pkg.sv
verilog/lane_status_filter.sv
verilog/ltssm_detect.sv
verilog/ts_os_builder.sv
verilog/os_serializer.sv
verilog/pcie_detect_top.sv
test/pcie_detect_tb.sv

// ==== Makefile ====
# Verilator flow for the receiver-detect front end

VERILATOR ?= verilator
TOP       ?= pcie_detect_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/pcie_detect_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module pcie_detect_tb
  import pcie_phy_pkg::*;
();

  localparam int NUM_LANES      = 4;
  localparam int TIMEOUT_CYCLES = 64;
  localparam int FILTER_LEN     = 3;
  localparam int NUM_SCEN       = 7;
  localparam int SCEN_CYCLES    = 3 * TIMEOUT_CYCLES + 200;
  localparam int DRAIN_CYCLES   = 100;
  localparam int SEED           = 59468;

  logic                 clk;
  logic                 rst;
  logic                 en;
  logic [2:0]           phy_rate;
  logic [NUM_LANES-1:0] lane_status;
  logic                 m_axis_ready;
  logic [NUM_LANES-1:0] lane_detected;
  logic [NUM_LANES-1:0] lane_elec_idle;
  logic [NUM_LANES-1:0] txdetectrx;
  logic                 det_success;
  logic                 det_error;
  os_beat_t             m_axis;
  logic                 m_axis_valid;

  int                   seq_errors = 0;
  int                   stream_errors = 0;
  int                   protocol_errors = 0;
  int                   beats_total = 0;
  int                   txdet_total = 0;
  logic [1:0]           word_pos = 2'd0;
  logic [NUM_LANES-1:0] probe_mask = '0;

  pcie_detect_top #(
    .NUM_LANES     (NUM_LANES),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
    .FILTER_LEN    (FILTER_LEN)
  ) dut0 (
    .clk_i           (clk),
    .rst_i           (rst),
    .en_i            (en),
    .phy_rate_i      (phy_rate),
    .lane_status_i   (lane_status),
    .lane_detected_o (lane_detected),
    .lane_elec_idle_o(lane_elec_idle),
    .txdetectrx_o    (txdetectrx),
    .success_o       (det_success),
    .error_o         (det_error),
    .m_axis_o        (m_axis),
    .m_axis_valid_o  (m_axis_valid),
    .m_axis_ready_i  (m_axis_ready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // random back-pressure with ready three cycles out of four on average
  initial begin
    m_axis_ready = 1'b0;
    forever begin
      @(posedge clk);
      #0.5;
      m_axis_ready = ($urandom_range(0, 3) != 0);
    end
  end

  // expected TS1 word with symbol 0 in the low byte of word 0
  function automatic logic [31:0] ts1_word(input logic [2:0] rate, input logic [1:0] idx);
    logic [7:0] rate_sym;
    rate_sym = {3'b000, rate, 2'b10};
    case (idx)
      2'd0:    ts1_word = {N_FTS_DEF, PAD_SYM, PAD_SYM, COM_SYM};
      2'd1:    ts1_word = {TS1_ID, TS1_ID, 8'h00, rate_sym};
      default: ts1_word = {4{TS1_ID}};
    endcase
  endfunction

  function automatic bit value_ok(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
    value_ok = 1'b1;
    assert (act === exp) else begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      value_ok = 1'b0;
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (!value_ok(name, exp, act)) begin
      seq_errors++;
    end
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #0.5;
  endtask

  // stream scoreboard sampled mid-cycle
  always @(negedge clk) begin
    if (!rst && m_axis_valid && m_axis_ready) begin
      if (!value_ok("stream data", ts1_word(phy_rate, word_pos), m_axis.data)) begin
        stream_errors++;
      end
      if (!value_ok("stream keep", 32'hF, 32'(m_axis.keep))) begin
        stream_errors++;
      end
      if (!value_ok("stream last", 32'(word_pos == 2'd3), 32'(m_axis.last))) begin
        stream_errors++;
      end
      if (!value_ok("stream word index", 32'(word_pos), 32'(m_axis.user.word_idx))) begin
        stream_errors++;
      end
      if (!value_ok("stream os flag", 32'd1, 32'(m_axis.user.os_flag))) begin
        stream_errors++;
      end
      if (!value_ok("stream symbol type", 32'(SYM_TS), 32'(m_axis.user.sym_type))) begin
        stream_errors++;
      end
      word_pos = word_pos + 2'd1;
      beats_total++;
    end
    if (|txdetectrx) begin
      txdet_total++;
    end
  end

  a_stall_stable: assert property (
    @(posedge clk) disable iff (rst)
    (m_axis_valid && !m_axis_ready) |=> (m_axis_valid && $stable(m_axis))
  ) else begin
    protocol_errors++;
    $display("stream beat changed or dropped while stalled at %0t", $time);
  end

  a_valid_until_last: assert property (
    @(posedge clk) disable iff (rst)
    (m_axis_valid && !(m_axis_ready && m_axis.last)) |=> m_axis_valid
  ) else begin
    protocol_errors++;
    $display("stream valid fell in the middle of an ordered set at %0t", $time);
  end

  a_rx_probe: assert property (
    @(posedge clk) disable iff (rst)
    (dut0.detect0.state_r == ST_RX) |-> (txdetectrx == probe_mask)
  ) else begin
    protocol_errors++;
    $display("transmit detect does not probe the silent lanes during rx at %0t", $time);
  end

  // one detect run where late is the lane status driven once rx is reached
  task automatic run_detect(input string name, input logic [NUM_LANES-1:0] pattern,
                            input logic [NUM_LANES-1:0] late);
    int                   n;
    int                   beats_start;
    int                   txdet_start;
    bit                   partial;
    bit                   exp_ok;
    logic [NUM_LANES-1:0] exp_det;
    logic [NUM_LANES-1:0] exp_idle;
    partial     = (pattern != '0) && (pattern != '1);
    phy_rate    = 3'($urandom_range(0, 7));
    lane_status = pattern;
    probe_mask  = ~pattern;
    repeat (2 + FILTER_LEN + 3) step_cycle();
    beats_start = beats_total;
    txdet_start = txdet_total;
    en = 1'b1;
    if (partial) begin
      n = 0;
      while ((dut0.detect0.state_r != ST_RX) && (n < SCEN_CYCLES)) begin
        step_cycle();
        n++;
      end
      if (n >= SCEN_CYCLES) begin
        seq_errors++;
        $display("%s: detect never reached the rx state", name);
      end
      check_value({name, " rx probe"}, 32'(probe_mask), 32'(txdetectrx));
      lane_status = late;
    end
    n = 0;
    while (!det_success && !det_error && (n < SCEN_CYCLES)) begin
      step_cycle();
      n++;
    end
    if (n >= SCEN_CYCLES) begin
      seq_errors++;
      $display("%s: no detect result before the time limit", name);
    end
    if (pattern == '1) begin
      exp_ok  = 1'b1;
      exp_det = '1;
    end else if (pattern == '0) begin
      exp_ok  = 1'b0;
      exp_det = '0;
    end else if ((late == '1) || (late == pattern)) begin
      exp_ok  = 1'b1;
      exp_det = late;
    end else begin
      exp_ok  = 1'b0;
      exp_det = '0;
    end
    exp_idle = exp_ok ? ~exp_det : '0;
    check_value({name, " success"}, 32'(exp_ok), 32'(det_success));
    check_value({name, " error"}, 32'(!exp_ok), 32'(det_error));
    check_value({name, " detected"}, 32'(exp_det), 32'(lane_detected));
    check_value({name, " elec idle"}, 32'(exp_idle), 32'(lane_elec_idle));
    check_value({name, " txdetectrx"}, 32'd0, 32'(txdetectrx));
    if (!partial && (txdet_total != txdet_start)) begin
      seq_errors++;
      $display("%s: transmit detect went high without an rx phase", name);
    end
    en = 1'b0;
    repeat (2) step_cycle();
    check_value({name, " success cleared"}, 32'd0, 32'(det_success));
    check_value({name, " error cleared"}, 32'd0, 32'(det_error));
    // the set in flight and any queued one must finish
    n = 0;
    while ((m_axis_valid || dut0.builder0.os_valid_o) && (n < DRAIN_CYCLES)) begin
      step_cycle();
      n++;
    end
    if (n >= DRAIN_CYCLES) begin
      seq_errors++;
      $display("%s: stream did not drain after quiet", name);
    end
    check_value({name, " set boundary"}, 32'd0, 32'(word_pos));
    if (beats_total == beats_start) begin
      seq_errors++;
      $display("%s: no ordered set was streamed during quiet", name);
    end
  endtask

  initial begin
    logic [NUM_LANES-1:0] p;
    logic [NUM_LANES-1:0] q;
    void'($urandom(SEED));
    rst         = 1'b1;
    en          = 1'b0;
    phy_rate    = 3'd0;
    lane_status = '0;
    repeat (16) @(posedge clk);
    #0.5;
    rst = 1'b0;
    repeat (4) step_cycle();
    check_value("reset success", 32'd0, 32'(det_success));
    check_value("reset error", 32'd0, 32'(det_error));
    check_value("reset txdetectrx", 32'd0, 32'(txdetectrx));
    check_value("reset detected", 32'd0, 32'(lane_detected));
    check_value("reset elec idle", 32'd0, 32'(lane_elec_idle));
    check_value("reset stream valid", 32'd0, 32'(m_axis_valid));

    run_detect("all lanes", '1, '1);
    run_detect("no lanes", '0, '0);
    p = 4'($urandom_range(1, 14));
    run_detect("partial", p, p);
    p = 4'($urandom_range(1, 14));
    q = p ^ 4'($urandom_range(1, 15));
    if (q == 4'hF) begin
      q = 4'h0;
    end
    run_detect("partial changed", p, q);
    run_detect("rerun all lanes", '1, '1);
    p = 4'($urandom_range(1, 14));
    run_detect("rerun partial", p, p);

    $display("errors: sequence %0d, stream %0d, protocol %0d",
             seq_errors, stream_errors, protocol_errors);
    if ((seq_errors + stream_errors + protocol_errors) == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (16 + NUM_SCEN * SCEN_CYCLES) @(posedge clk);
    $display("watchdog expired before the scenarios completed");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/pcie_detect_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module pcie_detect_top
  import pcie_phy_pkg::*;
#(
  parameter int NUM_LANES      = 4,
  parameter int TIMEOUT_CYCLES = 32'h0000DACA,
  parameter int FILTER_LEN     = 3
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 en_i,
  input  logic [2:0]           phy_rate_i,
  input  logic [NUM_LANES-1:0] lane_status_i,
  output logic [NUM_LANES-1:0] lane_detected_o,
  output logic [NUM_LANES-1:0] lane_elec_idle_o,
  output logic [NUM_LANES-1:0] txdetectrx_o,
  output logic                 success_o,
  output logic                 error_o,
  output os_beat_t             m_axis_o,
  output logic                 m_axis_valid_o,
  input  logic                 m_axis_ready_i
);

  logic [NUM_LANES-1:0] lane_stable;
  os_req_t              os_req;
  pcie_tsos_t           os;
  logic                 os_valid;
  logic                 os_take;

  lane_status_filter #(
    .NUM_LANES (NUM_LANES),
    .FILTER_LEN(FILTER_LEN)
  ) filter0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .lane_status_i(lane_status_i),
    .lane_stable_o(lane_stable)
  );

  ltssm_detect #(
    .NUM_LANES     (NUM_LANES),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) detect0 (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .en_i            (en_i),
    .phy_rate_i      (phy_rate_i),
    .lane_status_i   (lane_stable),
    .lane_detected_o (lane_detected_o),
    .lane_elec_idle_o(lane_elec_idle_o),
    .txdetectrx_o    (txdetectrx_o),
    .success_o       (success_o),
    .error_o         (error_o),
    .os_req_o        (os_req)
  );

  ts_os_builder builder0 (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .os_req_i  (os_req),
    .os_take_i (os_take),
    .os_o      (os),
    .os_valid_o(os_valid)
  );

  os_serializer ser0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .os_i          (os),
    .os_valid_i    (os_valid),
    .os_take_o     (os_take),
    .m_axis_o      (m_axis_o),
    .m_axis_valid_o(m_axis_valid_o),
    .m_axis_ready_i(m_axis_ready_i)
  );

endmodule

`default_nettype wire

// ==== verilog/os_serializer.sv ====
`timescale 1ns/100ps
`default_nettype none

module os_serializer
  import pcie_phy_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  pcie_tsos_t os_i,
  input  logic       os_valid_i,
  output logic       os_take_o,
  output os_beat_t   m_axis_o,
  output logic       m_axis_valid_o,
  input  logic       m_axis_ready_i
);

  localparam int IDX_W = $clog2(OS_WORDS);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(OS_WORDS - 1);

  pcie_tsos_t       os_q;
  logic [IDX_W-1:0] idx_r;
  logic             fire;
  logic             last_fire;

  assign fire      = m_axis_valid_o && m_axis_ready_i;
  assign last_fire = fire && (idx_r == LAST_IDX);

  // next set goes in right behind the last beat
  assign os_take_o = os_valid_i && (!m_axis_valid_o || last_fire);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      m_axis_valid_o <= 1'b0;
      idx_r          <= '0;
    end else if (os_take_o) begin
      m_axis_valid_o <= 1'b1;
      idx_r          <= '0;
    end else if (last_fire) begin
      m_axis_valid_o <= 1'b0;
      idx_r          <= '0;
    end else if (fire) begin
      idx_r <= idx_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (os_take_o) begin
      os_q <= os_i;
    end
  end

  always_comb begin
    m_axis_o.data          = os_q.w[idx_r];
    m_axis_o.keep          = '1;
    m_axis_o.last          = (idx_r == LAST_IDX);
    m_axis_o.user.os_flag  = 1'b1;
    m_axis_o.user.sym_type = SYM_TS;
    m_axis_o.user.word_idx = 5'(idx_r);
  end

  a_beat_held: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (m_axis_valid_o && !m_axis_ready_i) |=> (m_axis_valid_o && $stable(m_axis_o))
  );

endmodule

`default_nettype wire

// ==== verilog/ts_os_builder.sv ====
`timescale 1ns/100ps
`default_nettype none

module ts_os_builder
  import pcie_phy_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  os_req_t    os_req_i,
  input  logic       os_take_i,
  output pcie_tsos_t os_o,
  output logic       os_valid_o
);

  pcie_tsos_t os_c;
  logic       load;

  always_comb begin
    os_c.f.com        = COM_SYM;
    os_c.f.link_num   = PAD_SYM;
    os_c.f.lane_num   = PAD_SYM;
    os_c.f.n_fts      = N_FTS_DEF;
    // bit 1 is 2.5 GT/s and always set, faster rates above it
    os_c.f.rate_id    = {3'b000, os_req_i.rate, 2'b10};
    os_c.f.train_ctrl = '0;
    os_c.f.ts_id      = {10{TS1_ID}};
  end

  // slot is free when empty or handed over this cycle
  assign load = os_req_i.req && (!os_valid_o || os_take_i);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      os_valid_o <= 1'b0;
    end else if (load) begin
      os_valid_o <= 1'b1;
    end else if (os_take_i) begin
      os_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      os_o <= os_c;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ltssm_detect.sv ====
`timescale 1ns/100ps
`default_nettype none

module ltssm_detect
  import pcie_phy_pkg::*;
#(
  parameter int NUM_LANES      = 4,
  parameter int TIMEOUT_CYCLES = 32'h0000DACA
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 en_i,
  input  logic [2:0]           phy_rate_i,
  input  logic [NUM_LANES-1:0] lane_status_i,
  output logic [NUM_LANES-1:0] lane_detected_o,
  output logic [NUM_LANES-1:0] lane_elec_idle_o,
  output logic [NUM_LANES-1:0] txdetectrx_o,
  output logic                 success_o,
  output logic                 error_o,
  output os_req_t              os_req_o
);

  localparam logic [31:0] TIMEOUT = 32'(TIMEOUT_CYCLES);

  detect_state_e        state_r;
  detect_state_e        state_c;
  logic [31:0]          timer_r;
  logic [31:0]          timer_c;
  logic                 success_r;
  logic                 success_c;
  logic                 error_r;
  logic                 error_c;
  logic [NUM_LANES-1:0] captured_r;
  logic [NUM_LANES-1:0] captured_c;
  logic [NUM_LANES-1:0] detected_r;
  logic [NUM_LANES-1:0] detected_c;
  logic [NUM_LANES-1:0] elec_idle_r;
  logic [NUM_LANES-1:0] elec_idle_c;
  logic [NUM_LANES-1:0] txdet_r;
  logic [NUM_LANES-1:0] txdet_c;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_r     <= ST_IDLE;
      timer_r     <= '0;
      success_r   <= 1'b0;
      error_r     <= 1'b0;
      captured_r  <= '0;
      detected_r  <= '0;
      elec_idle_r <= '0;
      txdet_r     <= '0;
    end else begin
      state_r     <= state_c;
      timer_r     <= timer_c;
      success_r   <= success_c;
      error_r     <= error_c;
      captured_r  <= captured_c;
      detected_r  <= detected_c;
      elec_idle_r <= elec_idle_c;
      txdet_r     <= txdet_c;
    end
  end

  always_comb begin
    state_c     = state_r;
    timer_c     = timer_r;
    success_c   = success_r;
    error_c     = error_r;
    captured_c  = captured_r;
    detected_c  = detected_r;
    elec_idle_c = elec_idle_r;
    txdet_c     = txdet_r;
    case (state_r)
      ST_IDLE: begin
        if (en_i) begin
          // fresh run, forget the previous result
          timer_c     = '0;
          detected_c  = '0;
          elec_idle_c = '0;
          state_c     = ST_QUIET;
        end
      end
      ST_QUIET: begin
        timer_c = timer_r + 1'b1;
        if ((|lane_status_i) || (timer_r >= TIMEOUT)) begin
          timer_c    = '0;
          captured_c = lane_status_i;
          state_c    = ST_ACTIVE;
        end
      end
      ST_ACTIVE: begin
        if (captured_r == '1) begin
          success_c   = 1'b1;
          detected_c  = captured_r;
          elec_idle_c = '0;
          state_c     = ST_WAIT_EN_LOW;
        end else if (captured_r == '0) begin
          error_c = 1'b1;
          state_c = ST_WAIT_EN_LOW;
        end else begin
          // probe only the lanes that stayed silent
          txdet_c = ~captured_r;
          state_c = ST_RX;
        end
      end
      ST_RX: begin
        timer_c = timer_r + 1'b1;
        if (timer_r >= TIMEOUT) begin
          txdet_c = '0;
          state_c = ST_WAIT_EN_LOW;
          if ((lane_status_i == '1) || (lane_status_i == captured_r)) begin
            success_c   = 1'b1;
            detected_c  = lane_status_i;
            elec_idle_c = ~lane_status_i;
          end else begin
            error_c = 1'b1;
          end
        end
      end
      ST_WAIT_EN_LOW: begin
        if (!en_i) begin
          success_c = 1'b0;
          error_c   = 1'b0;
          state_c   = ST_IDLE;
        end
      end
      default: begin
        state_c = ST_IDLE;
      end
    endcase
  end

  assign lane_detected_o  = detected_r;
  assign lane_elec_idle_o = elec_idle_r;
  assign txdetectrx_o     = txdet_r;
  assign success_o        = success_r;
  assign error_o          = error_r;

  // training sets are requested for the whole of quiet
  assign os_req_o.req  = (state_r == ST_QUIET);
  assign os_req_o.rate = phy_rate_i;

  a_result_exclusive: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(success_o && error_o)
  );

  a_txdet_only_in_rx: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (state_r != ST_RX) |-> (txdetectrx_o == '0)
  );

endmodule

`default_nettype wire

// ==== verilog/lane_status_filter.sv ====
`timescale 1ns/100ps
`default_nettype none

module lane_status_filter #(
  parameter int NUM_LANES  = 4,
  parameter int FILTER_LEN = 3
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [NUM_LANES-1:0] lane_status_i,
  output logic [NUM_LANES-1:0] lane_stable_o
);

  localparam int CNT_W = $clog2(FILTER_LEN + 1);
  localparam logic [CNT_W-1:0] RUN_MAX = CNT_W'(FILTER_LEN);

  logic [NUM_LANES-1:0] sync1_r;
  logic [NUM_LANES-1:0] sync2_r;
  logic [NUM_LANES-1:0] prev_r;
  logic [CNT_W-1:0]     run_r;
  logic [CNT_W-1:0]     run_c;
  logic                 expired;

  // run length of identical samples including the current one
  always_comb begin
    if (sync2_r != prev_r) begin
      run_c = CNT_W'(1);
    end else if (run_r == RUN_MAX) begin
      run_c = run_r;
    end else begin
      run_c = run_r + 1'b1;
    end
    expired = (run_c >= RUN_MAX);
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      sync1_r       <= '0;
      sync2_r       <= '0;
      prev_r        <= '0;
      run_r         <= '0;
      lane_stable_o <= '0;
    end else begin
      sync1_r <= lane_status_i;
      sync2_r <= sync1_r;
      prev_r  <= sync2_r;
      run_r   <= run_c;
      if (expired) begin
        lane_stable_o <= sync2_r;
      end
    end
  end

  // a new output value must have been seen since FILTER_LEN samples back
  a_no_early_change: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !$stable(lane_stable_o) |->
      ((lane_stable_o == $past(sync2_r)) && ($past(sync2_r) == $past(sync2_r, FILTER_LEN)))
  );

endmodule

`default_nettype wire

// ==== verilog/pcie_phy_pkg.sv ====
`default_nettype none

package pcie_phy_pkg;

  localparam int OS_WORDS = 4;

  // ordered set symbols
  localparam logic [7:0] COM_SYM   = 8'hBC;
  localparam logic [7:0] PAD_SYM   = 8'hF7;
  localparam logic [7:0] TS1_ID    = 8'h4A;
  localparam logic [7:0] N_FTS_DEF = 8'd31;

  // sideband symbol type for training sets
  localparam logic [1:0] SYM_TS = 2'b01;

  // symbol 0 sits in the low byte of word 0, so fields run from the top down
  typedef struct packed {
    logic [9:0][7:0] ts_id;
    logic [7:0]      train_ctrl;
    logic [7:0]      rate_id;
    logic [7:0]      n_fts;
    logic [7:0]      lane_num;
    logic [7:0]      link_num;
    logic [7:0]      com;
  } pcie_ts_fields_t;

  typedef union packed {
    pcie_ts_fields_t             f;
    logic [OS_WORDS-1:0][31:0]   w;
  } pcie_tsos_t;

  typedef struct packed {
    logic       os_flag;
    logic [1:0] sym_type;
    logic [4:0] word_idx;
  } phy_user_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  keep;
    logic        last;
    phy_user_t   user;
  } os_beat_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_QUIET,
    ST_ACTIVE,
    ST_RX,
    ST_WAIT_EN_LOW
  } detect_state_e;

  typedef struct packed {
    logic       req;
    logic [2:0] rate;
  } os_req_t;

endpackage

`default_nettype wire
